/* vlog.f */
+incdir+verif
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/int_core.sv
verif/tb_int_core.sv

/* verif/tb_encode.svh */
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// one table row, the instruction and what the core must report for it
typedef struct packed {
    logic [31:0] inst;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        exc_en;
    logic [5:0]  ecode;
    logic        taken;
    logic [31:0] target;
} row_t;

function automatic logic [31:0] three_reg(input logic [4:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk);
    return {12'h001, funct, rk, rj, rd};
endfunction

function automatic logic [31:0] shift_imm(input logic [4:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] ui5);
    return {12'h004, funct, ui5, rj, rd};
endfunction

function automatic logic [31:0] reg_imm12(input logic [9:0] op, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [11:0] imm);
    return {op, imm, rj, rd};
endfunction

function automatic logic [31:0] upper_imm20(input logic [6:0] op, input logic [4:0] rd,
                                            input logic [19:0] imm);
    return {op, imm, rd};
endfunction

// conditional branches and jirl, offset in words
function automatic logic [31:0] branch16(input logic [5:0] op, input logic [4:0] rj,
                                         input logic [4:0] rd, input logic [15:0] offs);
    return {op, offs, rj, rd};
endfunction

function automatic logic [31:0] branch26(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};  // high part sits in the low bits
endfunction

function automatic logic [31:0] sys_code(input logic [4:0] funct, input logic [14:0] code);
    return {12'h002, funct, code};
endfunction

`endif

/* verif/tb_int_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_int_core;

    `include "tb_encode.svh"

    localparam logic [31:0] base_pc     = 32'h1c00_0000;
    localparam int          cycle_limit = 200;

    logic                clk = 1'b0;
    logic                resetn;
    logic                fetch_valid;
    core_pkg::fetch_t    fetch;
    core_pkg::redirect_t redirect;
    core_pkg::wb_t       wb;
    core_pkg::exc_t      exc;

    row_t        rows [0:63];
    logic        row_bad [0:63];
    int          n_rows;
    int          pipe_row [0:3];  // stage 1 is decode and stage 3 is result
    logic        pipe_live [0:3];
    int          errors;
    int          n_pass;
    int          n_fail;
    integer      seed;
    logic [31:0] ra;
    logic [31:0] rb;

    int_core UUT (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .redirect    (redirect),
        .wb          (wb),
        .exc         (exc)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] row_pc(input int i);
        return base_pc + i * 4;
    endfunction

    task automatic put_row(input logic [31:0] inst, input logic we, input logic [4:0] rd,
                           input logic [31:0] data, input logic trap, input logic [5:0] code,
                           input logic taken, input logic [31:0] target);
        rows[n_rows].inst   = inst;
        rows[n_rows].we     = we;
        rows[n_rows].waddr  = rd;
        rows[n_rows].wdata  = data;
        rows[n_rows].exc_en = trap;
        rows[n_rows].ecode  = code;
        rows[n_rows].taken  = taken;
        rows[n_rows].target = target;
        row_bad[n_rows]     = 1'b0;
        n_rows++;
    endtask

    task automatic put_write(input logic [31:0] inst, input logic [4:0] rd,
                             input logic [31:0] data);
        put_row(inst, rd != 5'd0, rd, data, 1'b0, 6'h00, 1'b0, 32'h0);  // r0 is never written
    endtask

    task automatic put_branch(input logic [31:0] inst, input logic taken);
        put_row(inst, 1'b0, 5'd0, 32'h0, 1'b0, 6'h00, taken, row_pc(n_rows) + 8);
    endtask

    task automatic put_trap(input logic [31:0] inst, input logic [5:0] code);
        put_row(inst, 1'b0, 5'd0, 32'h0, 1'b1, code, 1'b0, 32'h0);
    endtask

    // sits behind a taken branch and must never retire
    task automatic put_shadow();
        put_write(reg_imm12(10'h00a, 5'd30, 5'd0, 12'h007), 5'd30, 32'd7);
    endtask

    task automatic build_table();
        n_rows = 0;
        seed   = 32'h7358_1cee;
        ra     = $random(seed);
        rb     = $random(seed);
        put_write(upper_imm20(7'h0a, 4, ra[31:12]), 4, {ra[31:12], 12'h000});
        put_write(reg_imm12(10'h00e, 4, 4, ra[11:0]), 4, ra);
        put_write(upper_imm20(7'h0a, 5, rb[31:12]), 5, {rb[31:12], 12'h000});
        put_write(reg_imm12(10'h00e, 5, 5, rb[11:0]), 5, rb);
        put_write(three_reg(5'h00, 6, 4, 5), 6, ra + rb);  // add.w
        put_write(three_reg(5'h02, 7, 4, 5), 7, ra - rb);
        put_write(three_reg(5'h04, 8, 4, 5), 8,
                  {31'b0, (ra[31] != rb[31]) ? ra[31] : (ra < rb)});
        put_write(three_reg(5'h05, 9, 4, 5), 9, {31'b0, ra < rb});
        put_write(three_reg(5'h09, 10, 4, 5), 10, ra & rb);
        put_write(three_reg(5'h0a, 11, 4, 5), 11, ra | rb);
        put_write(three_reg(5'h08, 12, 4, 5), 12, ~(ra | rb));  // nor
        put_write(three_reg(5'h0b, 13, 4, 5), 13, ra ^ rb);
        put_write(three_reg(5'h0e, 14, 4, 5), 14, ra << rb[4:0]);
        put_write(three_reg(5'h0f, 15, 4, 5), 15, ra >> rb[4:0]);
        put_write(three_reg(5'h10, 16, 4, 5), 16,
                  (ra >> rb[4:0]) | ({32{ra[31]}} & ~(32'hffff_ffff >> rb[4:0])));
        put_write(reg_imm12(10'h00a, 17, 4, 12'hffb), 17, ra + 32'hffff_fffb);
        put_write(reg_imm12(10'h00d, 20, 4, 12'hf0f), 20, ra & 32'h0000_0f0f);
        put_write(reg_imm12(10'h00e, 21, 0, 12'h8a5), 21, 32'h0000_08a5);
        put_write(reg_imm12(10'h008, 18, 21, 12'hfff), 18, 32'd0);  // 0x8a5 is not below -1
        put_write(reg_imm12(10'h009, 19, 21, 12'h800), 19, 32'd1);  // 0x8a5 < 0xfffff800
        put_write(reg_imm12(10'h00f, 22, 4, 12'hfff), 22, ra ^ 32'h0000_0fff);
        put_write(shift_imm(5'h01, 23, 4, 7), 23, ra << 7);
        put_write(shift_imm(5'h09, 24, 4, 31), 24, ra >> 31);
        put_write(shift_imm(5'h11, 25, 4, 9), 25,
                  (ra >> 9) | ({32{ra[31]}} & ~(32'hffff_ffff >> 9)));
        put_write(upper_imm20(7'h0a, 26, 20'h80001), 26, 32'h8000_1000);
        put_write(upper_imm20(7'h0e, 27, 20'h00010), 27, row_pc(n_rows) + 32'h0001_0000);
        put_write(reg_imm12(10'h00a, 2, 0, 12'd100), 2, 32'd100);
        put_write(reg_imm12(10'h00a, 2, 2, 12'd1), 2, 32'd101);  // distance 1
        put_write(three_reg(5'h00, 3, 2, 2), 3, 32'd202);
        put_write(three_reg(5'h02, 3, 3, 2), 3, 32'd101);  // r2 at distance 2
        put_write(reg_imm12(10'h00a, 0, 0, 12'd123), 0, 32'd123);
        put_write(three_reg(5'h00, 28, 0, 0), 28, 32'd0);
        put_write(reg_imm12(10'h00a, 29, 0, 12'hfff), 29, 32'hffff_ffff);
        put_branch(branch16(6'h16, 2, 3, 2), 1'b1);  // beq
        put_shadow();
        put_branch(branch16(6'h17, 2, 3, 2), 1'b0);
        put_branch(branch16(6'h18, 29, 2, 2), 1'b1);  // blt -1 < 101
        put_shadow();
        put_branch(branch16(6'h19, 29, 2, 2), 1'b0);
        put_branch(branch16(6'h1a, 29, 2, 2), 1'b0);
        put_branch(branch16(6'h1b, 29, 2, 2), 1'b1);
        put_shadow();
        put_branch(branch16(6'h18, 2, 29, 2), 1'b0);
        put_branch(branch16(6'h19, 2, 29, 2), 1'b1);
        put_shadow();
        put_branch(branch16(6'h1a, 2, 29, 2), 1'b1);
        put_shadow();
        put_branch(branch16(6'h16, 2, 29, 2), 1'b0);
        put_branch(branch16(6'h17, 2, 29, 2), 1'b1);
        put_shadow();
        put_branch(branch16(6'h1b, 2, 29, 2), 1'b0);
        put_branch(branch26(6'h14, 2), 1'b1);  // b
        put_shadow();
        put_row(branch26(6'h15, 2), 1'b1, 5'd1, row_pc(n_rows) + 4, 1'b0, 6'h00,
                1'b1, row_pc(n_rows) + 8);  // bl
        put_shadow();
        // jirl off r1 which holds the pc of the row after bl
        put_row(branch16(6'h13, 1, 31, 3), 1'b1, 5'd31, row_pc(n_rows) + 4, 1'b0, 6'h00,
                1'b1, row_pc(n_rows - 1) + 12);
        put_shadow();
        put_write(three_reg(5'h00, 30, 31, 1), 30, row_pc(n_rows - 1) + row_pc(n_rows - 3));
        put_trap(sys_code(5'h16, 15'h0000), 6'h0b);  // syscall
        put_trap(sys_code(5'h14, 15'h0005), 6'h0c);
        put_trap(32'hffff_ffff, 6'h0d);
        put_trap(three_reg(5'h1f, 1, 2, 3), 6'h0d);  // unused 3R slot
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int r);
        assert (got === exp) else begin
            $display("CHECK FAILED %s row %0d: got %h expected %h", name, r, got, exp);
            errors++;
            if (r >= 0) begin
                row_bad[r] = 1'b1;
            end
        end
    endtask

    task automatic check_redirect(input int r, input logic live);
        if (r >= 0 && live) begin
            check_field("redirect.taken", redirect.taken, rows[r].taken, r);
            if (rows[r].taken) begin
                check_field("redirect.target", redirect.target, rows[r].target, r);
            end
        end else begin
            check_field("redirect.taken", redirect.taken, 32'h0, r);
        end
    endtask

    task automatic check_result(input int r, input logic live);
        if (r >= 0 && live) begin
            check_field("wb.we", wb.we, rows[r].we, r);
            if (rows[r].we) begin
                check_field("wb.waddr", wb.waddr, rows[r].waddr, r);
                check_field("wb.wdata", wb.wdata, rows[r].wdata, r);
            end
            check_field("exc.valid", exc.valid, rows[r].exc_en, r);
            if (rows[r].exc_en) begin
                check_field("exc.ecode", exc.ecode, rows[r].ecode, r);
                check_field("exc.pc", exc.pc, row_pc(r), r);
            end
        end else begin
            check_field("wb.we", wb.we, 32'h0, r);  // bubble or squashed item
            check_field("exc.valid", exc.valid, 32'h0, r);
        end
        if (r >= 0) begin
            if (row_bad[r]) begin
                n_fail++;
            end else begin
                n_pass++;
            end
            $display("row %0d pc %h inst %h%s: %s", r, row_pc(r), rows[r].inst,
                     live ? "" : " squashed", row_bad[r] ? "FAIL" : "ok");
        end
    endtask

    initial begin : run
        int          cyc;
        int          idx;
        int          s;
        logic        fetching;
        logic        done;
        logic        jump;
        logic [31:0] pc;
        logic [31:0] jump_target;

        resetn      = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        errors      = 0;
        n_pass      = 0;
        n_fail      = 0;
        build_table();
        for (s = 0; s < 4; s++) begin
            pipe_row[s]  = -1;
            pipe_live[s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;

        pc          = base_pc;
        jump        = 1'b0;
        jump_target = 32'h0;
        done        = 1'b0;
        cyc         = 0;
        while (!done && cyc < cycle_limit) begin
            @(posedge clk);
            #1;
            for (s = 3; s > 0; s--) begin
                pipe_row[s]  = pipe_row[s-1];
                pipe_live[s] = pipe_live[s-1];
            end
            idx      = int'((pc - base_pc) >> 2);
            fetching = (idx < n_rows);
            if (fetching) begin
                fetch_valid  = 1'b1;
                fetch.inst   = rows[idx].inst;
                fetch.pc     = pc;
                pipe_row[0]  = idx;
                pipe_live[0] = !jump;
                if (jump) begin
                    pc   = jump_target;  // item in the redirect cycle is dropped
                    jump = 1'b0;
                end else begin
                    if (rows[idx].taken) begin
                        jump        = 1'b1;
                        jump_target = rows[idx].target;
                    end
                    pc = pc + 4;
                end
            end else begin
                fetch_valid  = 1'b0;
                fetch        = '0;
                pipe_row[0]  = -1;
                pipe_live[0] = 1'b0;
            end
            @(negedge clk);
            check_redirect(pipe_row[1], pipe_live[1]);
            check_result(pipe_row[3], pipe_live[3]);
            done = !fetching && pipe_row[0] < 0 && pipe_row[1] < 0 && pipe_row[2] < 0;
            cyc++;
        end
        if (!done) begin
            $display("timeout: the pipeline did not drain within %0d cycles", cycle_limit);
            errors++;
        end

        $display("%0d tests passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/int_core.sv */
`timescale 1ns/1ps
`default_nettype none

module int_core (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       fetch_valid,
    input  wire  core_pkg::fetch_t    fetch,
    output core_pkg::redirect_t       redirect,
    output core_pkg::wb_t             wb,
    output core_pkg::exc_t            exc
);

    logic              dx_valid;
    core_pkg::dec_ex_t dx;
    logic              xr_valid;
    core_pkg::ex_res_t xr;
    core_pkg::wb_t     ex_fwd;

    decode_stage u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .ex_fwd      (ex_fwd),
        .wb          (wb),
        .dx_valid    (dx_valid),
        .dx          (dx),
        .redirect    (redirect)
    );

    execute_stage u_execute (
        .clk      (clk),
        .resetn   (resetn),
        .dx_valid (dx_valid),
        .dx       (dx),
        .xr_valid (xr_valid),
        .xr       (xr),
        .ex_fwd   (ex_fwd)
    );

    // write-back also feeds the register file inside decode
    result_stage u_result (
        .clk      (clk),
        .resetn   (resetn),
        .xr_valid (xr_valid),
        .xr       (xr),
        .wb       (wb),
        .exc      (exc)
    );

endmodule

`default_nettype wire

/* rtl/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      xr_valid,
    input  wire  core_pkg::ex_res_t  xr,
    output core_pkg::wb_t            wb,
    output core_pkg::exc_t           exc
);

    logic              rs_valid;
    core_pkg::ex_res_t rs_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rs_valid <= 1'b0;
        end else begin
            rs_valid <= xr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (xr_valid) begin
            rs_q <= xr;
        end
    end

    assign wb = '{
        we:    rs_valid & rs_q.rf_we & (rs_q.rf_waddr != '0),  // r0 never written
        waddr: rs_q.rf_waddr,
        wdata: rs_q.result
    };

    assign exc = '{valid: rs_valid & rs_q.exc_en, ecode: rs_q.ecode, pc: rs_q.pc};

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      dx_valid,
    input  wire  core_pkg::dec_ex_t  dx,
    output logic                     xr_valid,
    output core_pkg::ex_res_t        xr,
    output core_pkg::wb_t            ex_fwd
);

    logic                      ex_valid;
    core_pkg::dec_ex_t         ex_q;
    logic [core_pkg::xlen-1:0] a;
    logic [core_pkg::xlen-1:0] b;
    logic [4:0]                sh;
    logic [core_pkg::xlen-1:0] result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dx_valid) begin
            ex_q <= dx;
        end
    end

    assign a  = ex_q.src1;
    assign b  = ex_q.src2;
    assign sh = b[4:0];  // shift amount

    always_comb begin
        case (ex_q.alu_op)
            core_pkg::alu_add:   result = a + b;
            core_pkg::alu_sub:   result = a - b;
            core_pkg::alu_slt:   result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::alu_sltu:  result = {31'b0, a < b};
            core_pkg::alu_and:   result = a & b;
            core_pkg::alu_nor:   result = ~(a | b);
            core_pkg::alu_or:    result = a | b;
            core_pkg::alu_xor:   result = a ^ b;
            core_pkg::alu_sll:   result = a << sh;
            core_pkg::alu_srl:   result = a >> sh;
            core_pkg::alu_sra:   result = $unsigned($signed(a) >>> sh);
            core_pkg::alu_pass2: result = b;
            default:             result = '0;
        endcase
    end

    assign xr_valid = ex_valid;
    assign xr = '{
        rf_we:    ex_q.rf_we,
        rf_waddr: ex_q.rf_waddr,
        result:   result,
        pc:       ex_q.pc,
        exc_en:   ex_q.exc_en,
        ecode:    ex_q.ecode
    };

    // first forwarding source for decode
    assign ex_fwd = '{we: ex_valid & ex_q.rf_we, waddr: ex_q.rf_waddr, wdata: result};

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      fetch_valid,
    input  wire  core_pkg::fetch_t   fetch,
    input  wire  core_pkg::wb_t      ex_fwd,
    input  wire  core_pkg::wb_t      wb,
    output logic                     dx_valid,
    output core_pkg::dec_ex_t        dx,
    output core_pkg::redirect_t      redirect
);

    logic                            id_valid;
    core_pkg::fetch_t                id_q;

    logic [31:0]                     inst;
    logic [5:0]                      op6;
    logic [4:0]                      rd;
    logic [4:0]                      rj;
    logic [4:0]                      rk;
    logic [11:0]                     i12;
    logic [15:0]                     i16;
    logic [19:0]                     i20;
    logic [25:0]                     i26;

    core_pkg::alu_op_e               alu_op;
    logic [core_pkg::xlen-1:0]       imm;
    logic                            src1_pc;
    logic                            src2_imm;
    logic                            rd_src;
    logic                            gr_we;
    logic                            dst_r1;
    logic                            known;
    logic                            exc_sys;
    logic                            exc_brk;
    logic                            exc_en;
    logic [core_pkg::ecode_w-1:0]    ecode;

    logic [core_pkg::reg_addr_w-1:0] rf_raddr1;
    logic [core_pkg::reg_addr_w-1:0] rf_raddr2;
    logic [core_pkg::xlen-1:0]       rf_rdata1;
    logic [core_pkg::xlen-1:0]       rf_rdata2;
    logic [core_pkg::xlen-1:0]       rj_val;
    logic [core_pkg::xlen-1:0]       rkd_val;

    logic [core_pkg::xlen-1:0]       offs16;
    logic [core_pkg::xlen-1:0]       offs26;
    logic [core_pkg::xlen-1:0]       br_target;
    logic                            br_cond;

    function automatic logic [core_pkg::xlen-1:0] fwd_pick(
        input logic [core_pkg::reg_addr_w-1:0] ra,
        input logic [core_pkg::xlen-1:0]       rf_val,
        input core_pkg::wb_t                   ex_src,
        input core_pkg::wb_t                   wb_src
    );
        if (ra == '0) begin
            return '0;
        end else if (ex_src.we && ex_src.waddr == ra) begin
            return ex_src.wdata;  // newest first
        end else if (wb_src.we && wb_src.waddr == ra) begin
            return wb_src.wdata;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= fetch_valid & ~redirect.taken;  // squash wrong-path fetch
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            id_q <= fetch;
        end
    end

    assign inst = id_q.inst;
    assign op6  = inst[31:26];
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign i12  = inst[21:10];
    assign i16  = inst[25:10];
    assign i20  = inst[24:5];
    assign i26  = {inst[9:0], inst[25:10]};

    always_comb begin
        alu_op   = core_pkg::alu_add;
        imm      = '0;
        src1_pc  = 1'b0;
        src2_imm = 1'b1;
        rd_src   = 1'b0;
        gr_we    = 1'b1;
        dst_r1   = 1'b0;
        known    = 1'b1;
        exc_sys  = 1'b0;
        exc_brk  = 1'b0;
        if (inst[31:20] == core_pkg::op_alu_3r) begin
            src2_imm = 1'b0;
            case (inst[19:15])
                5'h00:   alu_op = core_pkg::alu_add;
                5'h02:   alu_op = core_pkg::alu_sub;
                5'h04:   alu_op = core_pkg::alu_slt;
                5'h05:   alu_op = core_pkg::alu_sltu;
                5'h08:   alu_op = core_pkg::alu_nor;
                5'h09:   alu_op = core_pkg::alu_and;
                5'h0a:   alu_op = core_pkg::alu_or;
                5'h0b:   alu_op = core_pkg::alu_xor;
                5'h0e:   alu_op = core_pkg::alu_sll;
                5'h0f:   alu_op = core_pkg::alu_srl;
                5'h10:   alu_op = core_pkg::alu_sra;
                default: known  = 1'b0;
            endcase
        end else if (inst[31:20] == core_pkg::op_sys) begin
            gr_we = 1'b0;
            case (inst[19:15])
                5'h14:   exc_brk = 1'b1;
                5'h16:   exc_sys = 1'b1;
                default: known   = 1'b0;
            endcase
        end else if (inst[31:20] == core_pkg::op_shift_imm) begin
            imm = {27'b0, rk};  // ui5
            case (inst[19:15])
                5'h01:   alu_op = core_pkg::alu_sll;
                5'h09:   alu_op = core_pkg::alu_srl;
                5'h11:   alu_op = core_pkg::alu_sra;
                default: known  = 1'b0;
            endcase
        end else if (inst[31:22] == core_pkg::op_addi) begin
            imm = {{20{i12[11]}}, i12};
        end else if (inst[31:22] == core_pkg::op_slti) begin
            imm    = {{20{i12[11]}}, i12};
            alu_op = core_pkg::alu_slt;
        end else if (inst[31:22] == core_pkg::op_sltui) begin
            imm    = {{20{i12[11]}}, i12};  // sign extended, compared unsigned
            alu_op = core_pkg::alu_sltu;
        end else if (inst[31:22] == core_pkg::op_andi) begin
            imm    = {20'b0, i12};
            alu_op = core_pkg::alu_and;
        end else if (inst[31:22] == core_pkg::op_ori) begin
            imm    = {20'b0, i12};
            alu_op = core_pkg::alu_or;
        end else if (inst[31:22] == core_pkg::op_xori) begin
            imm    = {20'b0, i12};
            alu_op = core_pkg::alu_xor;
        end else if (inst[31:25] == core_pkg::op_lu12i) begin
            imm    = {i20, 12'b0};
            alu_op = core_pkg::alu_pass2;
        end else if (inst[31:25] == core_pkg::op_pcaddu12i) begin
            imm     = {i20, 12'b0};
            src1_pc = 1'b1;
        end else begin
            case (op6)
                core_pkg::op_jirl: begin
                    src1_pc = 1'b1;  // link value pc+4
                    imm     = 32'd4;
                end
                core_pkg::op_bl: begin
                    src1_pc = 1'b1;
                    imm     = 32'd4;
                    dst_r1  = 1'b1;
                end
                core_pkg::op_b: gr_we = 1'b0;
                core_pkg::op_beq, core_pkg::op_bne, core_pkg::op_blt,
                core_pkg::op_bge, core_pkg::op_bltu, core_pkg::op_bgeu: begin
                    gr_we  = 1'b0;
                    rd_src = 1'b1;
                end
                default: known = 1'b0;
            endcase
        end
    end

    assign exc_en = exc_sys | exc_brk | ~known;
    assign ecode  = exc_sys ? core_pkg::ecode_sys :
                    exc_brk ? core_pkg::ecode_brk : core_pkg::ecode_ine;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = rd_src ? rd : rk;

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb)
    );

    assign rj_val  = fwd_pick(rf_raddr1, rf_rdata1, ex_fwd, wb);
    assign rkd_val = fwd_pick(rf_raddr2, rf_rdata2, ex_fwd, wb);

    always_comb begin
        case (op6)
            core_pkg::op_beq:  br_cond = (rj_val == rkd_val);
            core_pkg::op_bne:  br_cond = (rj_val != rkd_val);
            core_pkg::op_blt:  br_cond = ($signed(rj_val) < $signed(rkd_val));
            core_pkg::op_bge:  br_cond = ($signed(rj_val) >= $signed(rkd_val));
            core_pkg::op_bltu: br_cond = (rj_val < rkd_val);
            core_pkg::op_bgeu: br_cond = (rj_val >= rkd_val);
            core_pkg::op_b, core_pkg::op_bl, core_pkg::op_jirl: br_cond = 1'b1;
            default:           br_cond = 1'b0;
        endcase
    end

    assign offs16    = {{14{i16[15]}}, i16, 2'b0};
    assign offs26    = {{4{i26[25]}}, i26, 2'b0};
    assign br_target = (op6 == core_pkg::op_jirl) ? rj_val + offs16 :
                       (op6 == core_pkg::op_b || op6 == core_pkg::op_bl) ? id_q.pc + offs26 :
                       id_q.pc + offs16;

    assign redirect = '{taken: id_valid & br_cond, target: br_target};

    assign dx_valid = id_valid;
    assign dx = '{
        alu_op:   alu_op,
        src1:     src1_pc ? id_q.pc : rj_val,
        src2:     src2_imm ? imm : rkd_val,
        rf_we:    gr_we & ~exc_en,
        rf_waddr: dst_r1 ? 5'd1 : rd,
        pc:       id_q.pc,
        exc_en:   exc_en,
        ecode:    ecode
    };

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                                clk,
    input  wire  [core_pkg::reg_addr_w-1:0]    raddr1,
    input  wire  [core_pkg::reg_addr_w-1:0]    raddr2,
    output logic [core_pkg::xlen-1:0]          rdata1,
    output logic [core_pkg::xlen-1:0]          rdata2,
    input  wire  core_pkg::wb_t                wr
);

    logic [core_pkg::xlen-1:0] regs [1 << core_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // r0 is hardwired
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int ecode_w    = 6;

    // 3R and shift-immediate groups, matched on bits 31:20
    localparam logic [11:0] op_alu_3r    = 12'h001;
    localparam logic [11:0] op_sys       = 12'h002;  // syscall, break
    localparam logic [11:0] op_shift_imm = 12'h004;

    // 2RI12 group, bits 31:22
    localparam logic [9:0] op_slti  = 10'h008;
    localparam logic [9:0] op_sltui = 10'h009;
    localparam logic [9:0] op_addi  = 10'h00a;
    localparam logic [9:0] op_andi  = 10'h00d;
    localparam logic [9:0] op_ori   = 10'h00e;
    localparam logic [9:0] op_xori  = 10'h00f;

    // 1RI20, bits 31:25
    localparam logic [6:0] op_lu12i     = 7'h0a;
    localparam logic [6:0] op_pcaddu12i = 7'h0e;

    // branches, bits 31:26
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;
    localparam logic [5:0] op_blt  = 6'h18;
    localparam logic [5:0] op_bge  = 6'h19;
    localparam logic [5:0] op_bltu = 6'h1a;
    localparam logic [5:0] op_bgeu = 6'h1b;

    localparam logic [ecode_w-1:0] ecode_sys = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine = 6'h0d;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass2  // lu12i.w
    } alu_op_e;

    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       pc;
        logic                  exc_en;
        logic [ecode_w-1:0]    ecode;
    } dec_ex_t;

    typedef struct packed {
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       pc;
        logic                  exc_en;
        logic [ecode_w-1:0]    ecode;
    } ex_res_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } wb_t;

    typedef struct packed {
        logic               valid;
        logic [ecode_w-1:0] ecode;
        logic [xlen-1:0]    pc;
    } exc_t;

endpackage

`default_nettype wire
